// File: verilog/game_pkg.sv
package game_pkg;

    // ------------------------------
    // a frame runs from DEPLOY through FINISH
    typedef enum logic [2:0] {
        PH_REST,
        PH_INIT,
        PH_DEPLOY,
        PH_PLACE,
        PH_HURT,
        PH_PURSE,
        PH_INCOME,
        PH_FINISH
    } phase_t;

    typedef logic [14:0] money_t;
    typedef logic [2:0]  level_t;

    localparam int     NUM_LEVELS = 8;
    localparam level_t MAX_LEVEL  = level_t'(NUM_LEVELS - 1);
    localparam int     CD_W       = 5;  // cooldown runs 31 frames

    // ------------------------------
    // economy tables by purse level
    localparam money_t UPGRADE_PRICE [NUM_LEVELS] = '{
        15'd50, 15'd100, 15'd150, 15'd200, 15'd300, 15'd400, 15'd500, 15'd0
    };

    localparam money_t MONEY_CAP [NUM_LEVELS] = '{
        15'd200, 15'd400, 15'd600, 15'd800, 15'd1200, 15'd1600, 15'd2000, 15'd2500
    };

    // added once per frame
    localparam logic [2:0] INCOME [NUM_LEVELS] = '{
        3'd1, 3'd2, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd5
    };

endpackage

// File: verilog/unit_pkg.sv
package unit_pkg;

    // button b deploys type b
    typedef enum logic [1:0] {
        KILLER_BIRD,
        WHITE_BEAR,
        METAL_DUCK,
        BLACK_BEAR
    } unit_type_t;

    typedef logic [11:0] hp_t;

    // ------------------------------
    // one roster slot
    typedef struct packed {
        logic       alive;
        unit_type_t utype;
        hp_t        hp;
        hp_t        dmg;    // damage pending until the hurt phase
    } unit_rec_t;

    localparam game_pkg::money_t UNIT_COST [4] = '{
        15'd10, 15'd25, 15'd40, 15'd60
    };

    localparam hp_t UNIT_HP [4] = '{
        12'd100, 12'd300, 12'd200, 12'd500
    };

endpackage

// File: verilog/econ_if.sv
`timescale 1ns/100ps

interface econ_if;
    game_pkg::level_t level;
    logic             upgrade_go;       // level step and charge in the same cycle
    game_pkg::money_t upgrade_price;
    game_pkg::money_t money_cap;
    game_pkg::money_t money;

    modport cfg (
        output level,
        output upgrade_go,
        output upgrade_price,
        output money_cap,
        input  money
    );

    modport ledger (
        input  level,
        input  upgrade_go,
        input  upgrade_price,
        input  money_cap,
        output money
    );
endinterface

// File: verilog/tick_sequencer.sv
`timescale 1ns/100ps

module tick_sequencer (
    input  logic             clk_25MHz,
    input  logic             rst,
    input  logic             playing,
    input  logic             game_init,
    input  logic             frame_tick,
    output game_pkg::phase_t phase
);

    game_pkg::phase_t phase_nxt;

    always_comb begin
        if (!playing) begin
            // outside play only a single init cycle leaves rest
            if (phase == game_pkg::PH_REST && game_init) begin
                phase_nxt = game_pkg::PH_INIT;
            end else begin
                phase_nxt = game_pkg::PH_REST;
            end
        end else begin
            case (phase)
                game_pkg::PH_REST:   phase_nxt = frame_tick ? game_pkg::PH_DEPLOY
                                                            : game_pkg::PH_REST;
                game_pkg::PH_DEPLOY: phase_nxt = game_pkg::PH_PLACE;
                game_pkg::PH_PLACE:  phase_nxt = game_pkg::PH_HURT;
                game_pkg::PH_HURT:   phase_nxt = game_pkg::PH_PURSE;
                game_pkg::PH_PURSE:  phase_nxt = game_pkg::PH_INCOME;
                game_pkg::PH_INCOME: phase_nxt = game_pkg::PH_FINISH;
                default:             phase_nxt = game_pkg::PH_REST;   // finish and init
            endcase
        end
    end

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            phase <= game_pkg::PH_REST;
        end else begin
            phase <= phase_nxt;
        end
    end

endmodule

// File: verilog/deploy_buttons.sv
`timescale 1ns/100ps

module deploy_buttons #(
    parameter int NUM_SLOTS = 8
) (
    input  logic                 clk_25MHz,
    input  logic                 rst,
    input  game_pkg::phase_t     phase,
    input  logic [3:0]           deploy_press,
    input  game_pkg::money_t     money,
    input  logic                 roster_full,
    output logic                 deploy_go,
    output unit_pkg::unit_type_t deploy_type,
    output game_pkg::money_t     deploy_cost,
    output logic [3:0]           cd_busy
);

    // a roster narrower than the button row leaves the upper buttons idle
    localparam int NUM_BTN = (NUM_SLOTS < 4) ? NUM_SLOTS : 4;

    logic [3:0]                req;
    logic [game_pkg::CD_W-1:0] cd [4];
    logic                      any_req;
    unit_pkg::unit_type_t      pick;
    unit_pkg::unit_type_t      type_q;

    // lowest pending button wins
    always_comb begin
        any_req = 1'b0;
        pick    = unit_pkg::KILLER_BIRD;
        for (int b = NUM_BTN - 1; b >= 0; b--) begin
            if (req[b]) begin
                any_req = 1'b1;
                pick    = unit_pkg::unit_type_t'(2'(b));
            end
        end
    end

    assign deploy_cost = unit_pkg::UNIT_COST[pick];
    assign deploy_go   = (phase == game_pkg::PH_DEPLOY) && any_req && !roster_full
                         && (money >= deploy_cost);
    assign deploy_type = type_q;

    always_ff @(posedge clk_25MHz) begin
        if (phase == game_pkg::PH_DEPLOY) begin
            type_q <= pick;     // held for the place stage
        end
    end

    // ------------------------------
    // request latches and cooldowns
    always_ff @(posedge clk_25MHz) begin
        if (rst || phase == game_pkg::PH_INIT) begin
            req <= '0;
            for (int b = 0; b < 4; b++) begin
                cd[b] <= '0;
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (phase == game_pkg::PH_DEPLOY) begin
                    req[b] <= 1'b0;
                end else if (b < NUM_BTN && deploy_press[b] && cd[b] == '0) begin
                    req[b] <= 1'b1;
                end

                if (deploy_go && pick == 2'(b)) begin
                    cd[b] <= 1;
                end else if (phase == game_pkg::PH_FINISH && cd[b] != '0) begin
                    cd[b] <= cd[b] + 1'b1;  // wraps to zero after 31
                end
            end
        end
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            cd_busy[b] = (cd[b] != '0);
        end
    end

endmodule

// File: verilog/army_roster.sv
`timescale 1ns/100ps

module army_roster #(
    parameter int NUM_SLOTS = 8
) (
    input  logic                 clk_25MHz,
    input  logic                 rst,
    input  game_pkg::phase_t     phase,
    input  unit_pkg::unit_type_t deploy_type,
    input  logic                 spawn,
    input  logic                 hit_valid,
    input  logic [2:0]           hit_slot,
    input  unit_pkg::hp_t        hit_amount,
    output unit_pkg::unit_rec_t  slots [NUM_SLOTS],
    output logic                 roster_full
);

    logic [NUM_SLOTS-1:0] alive;
    logic [NUM_SLOTS-1:0] free_sel;     // one-hot lowest free slot
    unit_pkg::hp_t        dmg_nxt [NUM_SLOTS];

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            alive[i] = slots[i].alive;
        end
    end

    assign free_sel    = ~alive & (alive + 1'b1);
    assign roster_full = &alive;

    // hurt phase restarts the pending damage sum
    always_comb begin
        unit_pkg::hp_t base;
        unit_pkg::hp_t add;
        logic [12:0]   sum;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            base = (phase == game_pkg::PH_HURT) ? '0 : slots[i].dmg;
            add  = (hit_valid && hit_slot == 3'(i)) ? hit_amount : '0;
            sum  = {1'b0, base} + {1'b0, add};
            dmg_nxt[i] = sum[12] ? '1 : sum[11:0];  // saturate
        end
    end

    // ------------------------------
    // slot update
    always_ff @(posedge clk_25MHz) begin
        if (rst || phase == game_pkg::PH_INIT) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slots[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (spawn && phase == game_pkg::PH_PLACE && free_sel[i]) begin
                    slots[i].alive <= 1'b1;
                    slots[i].utype <= deploy_type;
                    slots[i].hp    <= unit_pkg::UNIT_HP[deploy_type];
                    slots[i].dmg   <= '0;
                end else if (slots[i].alive) begin
                    slots[i].dmg <= dmg_nxt[i];
                    if (phase == game_pkg::PH_HURT) begin
                        if (slots[i].dmg >= slots[i].hp) begin
                            slots[i].alive <= 1'b0;
                            slots[i].dmg   <= '0;
                        end else begin
                            slots[i].hp <= slots[i].hp - slots[i].dmg;
                        end
                    end
                end
            end
        end
    end

endmodule

// File: verilog/purse_config.sv
`timescale 1ns/100ps

module purse_config (
    input  logic             clk_25MHz,
    input  logic             rst,
    input  game_pkg::phase_t phase,
    input  logic             upgrade_press,
    econ_if.cfg              econ
);

    logic req;

    // level lookups
    assign econ.upgrade_price = game_pkg::UPGRADE_PRICE[econ.level];
    assign econ.money_cap     = game_pkg::MONEY_CAP[econ.level];

    assign econ.upgrade_go = (phase == game_pkg::PH_PURSE) && req
                             && (econ.level != game_pkg::MAX_LEVEL)
                             && (econ.money >= econ.upgrade_price);

    always_ff @(posedge clk_25MHz) begin
        if (rst || phase == game_pkg::PH_INIT) begin
            req        <= 1'b0;
            econ.level <= '0;
        end else begin
            if (phase == game_pkg::PH_PURSE) begin
                req <= 1'b0;
            end else if (upgrade_press) begin
                req <= 1'b1;
            end

            if (econ.upgrade_go) begin
                econ.level <= econ.level + 1'b1;
            end
        end
    end

endmodule

// File: verilog/money_ledger.sv
`timescale 1ns/100ps

module money_ledger (
    input  logic             clk_25MHz,
    input  logic             rst,
    input  game_pkg::phase_t phase,
    input  logic             deploy_go,
    input  game_pkg::money_t deploy_cost,
    econ_if.ledger           econ,
    output logic             able_to_upgrade
);

    logic [15:0] income_sum;    // one spare bit before the clamp

    assign income_sum = {1'b0, econ.money} + 16'(game_pkg::INCOME[econ.level]);

    assign able_to_upgrade = (econ.money >= econ.upgrade_price)
                             && (econ.level != game_pkg::MAX_LEVEL);

    always_ff @(posedge clk_25MHz) begin
        if (rst || phase == game_pkg::PH_INIT) begin
            econ.money <= '0;
        end else begin
            case (phase)
                game_pkg::PH_DEPLOY: begin
                    if (deploy_go) econ.money <= econ.money - deploy_cost;
                end
                game_pkg::PH_PURSE: begin
                    if (econ.upgrade_go) econ.money <= econ.money - econ.upgrade_price;
                end
                game_pkg::PH_INCOME: begin
                    if (income_sum > {1'b0, econ.money_cap}) begin
                        econ.money <= econ.money_cap;
                    end else begin
                        econ.money <= income_sum[14:0];
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// File: verilog/game_engine.sv
`timescale 1ns/100ps

module game_engine #(
    parameter int NUM_SLOTS = 8
) (
    input  logic                    clk_25MHz,
    input  logic                    rst,
    input  logic                    playing,
    input  logic                    game_init,
    input  logic                    frame_tick,
    input  logic [3:0]              deploy_press,
    input  logic                    upgrade_press,
    input  logic                    hit_valid,
    input  logic [2:0]              hit_slot,
    input  logic [11:0]             hit_amount,
    output logic [14:0]             money,
    output logic [2:0]              purse_level,
    output logic                    able_to_upgrade,
    output logic [3:0]              cd_busy,
    output logic [NUM_SLOTS-1:0]    army_alive,
    output logic [2*NUM_SLOTS-1:0]  army_type,
    output logic [12*NUM_SLOTS-1:0] army_hp
);

    game_pkg::phase_t     phase;
    logic                 deploy_go;
    unit_pkg::unit_type_t deploy_type;
    game_pkg::money_t     deploy_cost;
    logic                 roster_full;
    logic                 spawn;
    unit_pkg::unit_rec_t  slots [NUM_SLOTS];

    econ_if econ ();

    tick_sequencer tick_sequencer_i (
        .clk_25MHz  (clk_25MHz),
        .rst        (rst),
        .playing    (playing),
        .game_init  (game_init),
        .frame_tick (frame_tick),
        .phase      (phase)
    );

    deploy_buttons #(.NUM_SLOTS(NUM_SLOTS)) deploy_buttons_i (
        .clk_25MHz    (clk_25MHz),
        .rst          (rst),
        .phase        (phase),
        .deploy_press (deploy_press),
        .money        (econ.money),
        .roster_full  (roster_full),
        .deploy_go    (deploy_go),
        .deploy_type  (deploy_type),
        .deploy_cost  (deploy_cost),
        .cd_busy      (cd_busy)
    );

    // place stage of the deploy pipeline
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            spawn <= 1'b0;
        end else begin
            spawn <= deploy_go;
        end
    end

    army_roster #(.NUM_SLOTS(NUM_SLOTS)) army_roster_i (
        .clk_25MHz   (clk_25MHz),
        .rst         (rst),
        .phase       (phase),
        .deploy_type (deploy_type),
        .spawn       (spawn),
        .hit_valid   (hit_valid),
        .hit_slot    (hit_slot),
        .hit_amount  (hit_amount),
        .slots       (slots),
        .roster_full (roster_full)
    );

    purse_config purse_config_i (
        .clk_25MHz     (clk_25MHz),
        .rst           (rst),
        .phase         (phase),
        .upgrade_press (upgrade_press),
        .econ          (econ.cfg)
    );

    money_ledger money_ledger_i (
        .clk_25MHz       (clk_25MHz),
        .rst             (rst),
        .phase           (phase),
        .deploy_go       (deploy_go),
        .deploy_cost     (deploy_cost),
        .econ            (econ.ledger),
        .able_to_upgrade (able_to_upgrade)
    );

    // ------------------------------
    // flatten roster onto plain ports
    assign money       = econ.money;
    assign purse_level = econ.level;

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_flat
        assign army_alive[i]         = slots[i].alive;
        assign army_type[2*i +: 2]   = slots[i].utype;
        assign army_hp[12*i +: 12]   = slots[i].hp;
    end

endmodule

// File: testbench/clock_gen.sv
`timescale 1ns/100ps

module clock_gen (
    output logic clk_25MHz,
    output logic rst
);

    initial begin
        clk_25MHz = 1'b0;
        forever #20 clk_25MHz = ~clk_25MHz;    // 40 ns period
    end

    // reset held over the first 3 rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk_25MHz);
        #2 rst = 1'b0;
    end

endmodule

// File: testbench/tb_game_engine.sv
`timescale 1ns/100ps

module tb_game_engine;

    logic            clk_25MHz;
    logic            rst;
    logic            playing;
    logic            game_init;
    logic            frame_tick;
    logic [3:0]      deploy_press;
    logic            upgrade_press;
    logic            hit_valid;
    logic [2:0]      hit_slot;
    logic [11:0]     hit_amount;
    logic [14:0]     money;
    logic [2:0]      purse_level;
    logic            able_to_upgrade;
    logic [3:0]      cd_busy;
    logic [7:0]      army_alive;
    logic [15:0]     army_type;
    logic [95:0]     army_hp;

    int              errors;
    int              checks;
    int              wd_cycles;
    int              total_frames;
    int              fd;
    int              nf;
    int              a;
    int              b;
    logic [8*96-1:0] line;
    logic [8*16-1:0] cmd;
    logic [8*16-1:0] field;

    clock_gen clock_gen_i (
        .clk_25MHz (clk_25MHz),
        .rst       (rst)
    );

    game_engine game_engine_i (
        .clk_25MHz       (clk_25MHz),
        .rst             (rst),
        .playing         (playing),
        .game_init       (game_init),
        .frame_tick      (frame_tick),
        .deploy_press    (deploy_press),
        .upgrade_press   (upgrade_press),
        .hit_valid       (hit_valid),
        .hit_slot        (hit_slot),
        .hit_amount      (hit_amount),
        .money           (money),
        .purse_level     (purse_level),
        .able_to_upgrade (able_to_upgrade),
        .cd_busy         (cd_busy),
        .army_alive      (army_alive),
        .army_type       (army_type),
        .army_hp         (army_hp)
    );

    // ------------------------------
    // inputs change 2 ns after the edge
    task automatic next_cycle();
        @(posedge clk_25MHz);
        #2;
    endtask

    task automatic run_frame();
        int gap;
        gap = $urandom % 2;     // idle gap before the tick
        repeat (gap) next_cycle();
        frame_tick = 1'b1;
        next_cycle();
        frame_tick = 1'b0;
        repeat (8) next_cycle();    // frame is 6 cycles
    endtask

    task automatic start_game();
        playing   = 1'b0;
        game_init = 1'b1;
        next_cycle();
        game_init = 1'b0;
        repeat (2) next_cycle();
        playing = 1'b1;
        next_cycle();
    endtask

    // ------------------------------
    // checks
    task automatic compare(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_field(input logic [8*16-1:0] name, input int v1, input int v2);
        case (name)
            "money": compare("money", money, v1);
            "level": compare("purse_level", purse_level, v1);
            "able":  compare("able_to_upgrade", able_to_upgrade, v1);
            "cd":    compare("cd_busy", cd_busy, v1);
            "alive": compare("army_alive", army_alive, v1);
            "type":  compare($sformatf("army_type[%0d]", v1), army_type[2*v1 +: 2], v2);
            "hp":    compare($sformatf("army_hp[%0d]", v1), army_hp[12*v1 +: 12], v2);
            default: begin
                errors++;
                $display("unknown field %0s in an expect line", name);
            end
        endcase
    endtask

    initial begin : watchdog
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk_25MHz);
        $display("timeout after %0d cycles, stimulus did not complete", wd_cycles);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        errors        = 0;
        checks        = 0;
        wd_cycles     = 0;
        total_frames  = 0;
        playing       = 1'b0;
        game_init     = 1'b0;
        frame_tick    = 1'b0;
        deploy_press  = '0;
        upgrade_press = 1'b0;
        hit_valid     = 1'b0;
        hit_slot      = '0;
        hit_amount    = '0;
        void'($urandom(32'h2a618283));

        fd = $fopen("testbench/game_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file");
        end else begin
            // first pass sizes the watchdog
            while ($fgets(line, fd) != 0) begin
                nf = $sscanf(line, "%s %d", cmd, a);
                if (nf == 2 && cmd == "frame") total_frames += a;
            end
            $fclose(fd);
            wd_cycles = total_frames * 10 + 200;

            fd = $fopen("testbench/game_stim.txt", "r");
            wait (rst == 1'b0);
            while ($fgets(line, fd) != 0) begin
                nf = $sscanf(line, "%s", cmd);
                if (nf >= 1 && cmd != "#") begin
                    case (cmd)
                        "init": start_game();
                        "frame": begin
                            nf = $sscanf(line, "%s %d", cmd, a);
                            repeat (a) run_frame();
                        end
                        "press": begin
                            nf = $sscanf(line, "%s %d", cmd, a);
                            deploy_press = 4'b0001 << a;
                            next_cycle();
                            deploy_press = '0;
                        end
                        "upgrade": begin
                            upgrade_press = 1'b1;
                            next_cycle();
                            upgrade_press = 1'b0;
                        end
                        "hit": begin
                            nf = $sscanf(line, "%s %d %d", cmd, a, b);
                            hit_valid  = 1'b1;
                            hit_slot   = a[2:0];
                            hit_amount = b[11:0];
                            next_cycle();
                            hit_valid = 1'b0;
                        end
                        "expect": begin
                            nf = $sscanf(line, "%s %s %d %d", cmd, field, a, b);
                            check_field(field, a, b);
                        end
                        default: begin
                            errors++;
                            $display("unknown command %0s in the stimulus file", cmd);
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/game_stim.txt
# command with arguments: init, frame n, press b, upgrade, hit slot amount
# expect field value, or expect type|hp slot value; all decimal
expect money 0
expect level 0
expect alive 0
init
frame 5
expect money 5
expect able 0
# too poor for a metal duck
press 2
frame 1
expect money 6
expect alive 0
frame 19
press 1
frame 1
expect alive 1
expect type 0 1
expect hp 0 300
expect money 1
expect cd 2
# second press lands in the cooldown
press 1
frame 29
expect alive 1
expect cd 2
expect money 30
frame 1
expect cd 0
# buttons 0 and 2 together
press 2
press 0
frame 1
expect alive 3
expect type 1 0
expect hp 1 100
expect money 22
expect cd 1
hit 1 120
hit 0 50
hit 0 60
frame 1
expect alive 1
expect hp 0 190
frame 27
expect money 50
expect able 1
upgrade
frame 1
expect level 1
expect money 2
expect able 0
frame 200
expect money 400
expect able 1
# fill the roster
press 0
frame 1
press 1
frame 1
press 2
frame 1
press 3
frame 1
expect cd 15
expect money 273
expect type 4 3
expect hp 4 500
frame 27
expect cd 14
press 0
frame 1
press 1
frame 1
press 2
frame 1
expect alive 255
expect money 258
press 3
frame 1
expect alive 255
expect money 260
expect cd 7
init
expect alive 0
expect money 0
frame 205
expect money 200

// File: src.f
verilog/game_pkg.sv
verilog/unit_pkg.sv
verilog/econ_if.sv
verilog/tick_sequencer.sv
verilog/deploy_buttons.sv
verilog/army_roster.sv
verilog/purse_config.sv
verilog/money_ledger.sv
verilog/game_engine.sv
testbench/clock_gen.sv
testbench/tb_game_engine.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_game_engine \
    -f src.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "TB FAILED" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0
